// File: build.f
+incdir+source
source/mm_pkg.sv
source/n2r_buffer.sv
source/mac_core.sv
source/apb_regs.sv
source/mm_top.sv
verification/tb_mm_top.sv

// File: run.sh
#!/bin/sh
# Compile and run the matrix-vector engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_mm_top -f build.f -o tb_mm_top

out=$(./obj_dir/tb_mm_top)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: pass message not found"
    exit 1
fi

// File: source/apb_regs.sv
/* APB3 register block: weight vector, latched block results and status with a
   pending flag and a completed block count */
`timescale 1ns/1ns
`include "mm_macros.svh"

module apb_regs import mm_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // APB3 slave
    input  addr_t       paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // Engine side
    input  acc_t        result_0,
    input  acc_t        result_1,
    input  acc_t        result_2,
    input  acc_t        result_3,
    input  logic        block_done,
    output data_t       weight_0,
    output data_t       weight_1,
    output data_t       weight_2,
    output data_t       weight_3,
    output data_t       weight_4,
    output data_t       weight_5,
    output data_t       weight_6,
    output data_t       weight_7,
    output logic        results_pending
);

    localparam addr_t WEIGHT_END = addr_t'(`MM_ADDR_WEIGHT + 4*`MM_COL);
    localparam addr_t RESULT_END = addr_t'(`MM_ADDR_RESULT + 4*`MM_BLOCK_ROWS);

    data_t      weights [0:`MM_COL-1];
    acc_t       results [0:`MM_BLOCK_ROWS-1];
    logic [7:0] block_count;                        // Wraps at 256
    addr_t      offset_w, offset_r;
    logic       hit_weight, hit_result, hit_status;
    logic       access, wr_en;

    logic [$clog2(`MM_COL)-1:0]        weight_idx;
    logic [$clog2(`MM_BLOCK_ROWS)-1:0] result_idx;

    // Address decode, word aligned only
    assign offset_w   = paddr - `MM_ADDR_WEIGHT;
    assign offset_r   = paddr - `MM_ADDR_RESULT;
    assign weight_idx = offset_w[2 +: $clog2(`MM_COL)];
    assign result_idx = offset_r[2 +: $clog2(`MM_BLOCK_ROWS)];
    assign hit_weight = (paddr >= `MM_ADDR_WEIGHT) && (paddr < WEIGHT_END) && (paddr[1:0] == 2'b00);
    assign hit_result = (paddr >= `MM_ADDR_RESULT) && (paddr < RESULT_END) && (paddr[1:0] == 2'b00);
    assign hit_status = (paddr == `MM_ADDR_STATUS);

    assign access  = psel && penable;
    assign wr_en   = access && pwrite;
    assign pready  = 1'b1;                          // No wait states
    // Unmapped address, or a write to read-only results
    assign pslverr = access && (!(hit_weight || hit_result || hit_status) || (pwrite && hit_result));

    always_comb begin
        prdata = '0;
        if (hit_weight) begin
            prdata = {16'b0, weights[weight_idx]};
        end else if (hit_result) begin
            prdata = results[result_idx];
        end else if (hit_status) begin
            prdata = {16'b0, block_count, 7'b0, results_pending};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MM_COL; i++) begin
                weights[i] <= '0;
            end
            results_pending <= 1'b0;
            block_count     <= '0;
        end else begin
            if (wr_en && hit_weight) begin
                weights[weight_idx] <= pwdata[15:0];
            end
            if (block_done) begin
                results_pending <= 1'b1;            // New results win over a clear
                block_count     <= block_count + 1'b1;
            end else if (wr_en && hit_status && pwdata[0]) begin
                results_pending <= 1'b0;            // Write 1 to clear
            end
        end
    end

    // Result capture
    always_ff @(posedge clk) begin
        if (block_done) begin
            results[0] <= result_0;
            results[1] <= result_1;
            results[2] <= result_2;
            results[3] <= result_3;
        end
    end

    assign weight_0 = weights[0];
    assign weight_1 = weights[1];
    assign weight_2 = weights[2];
    assign weight_3 = weights[3];
    assign weight_4 = weights[4];
    assign weight_5 = weights[5];
    assign weight_6 = weights[6];
    assign weight_7 = weights[7];

endmodule

// File: source/mac_core.sv
/* Multiply-accumulate core for two rows of a block: one weighted column pair
   per beat, dot products latched on the last beat */
`timescale 1ns/1ns
`include "mm_macros.svh"

module mac_core import mm_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  chunk_t chunk_a,        // First owned row
    input  chunk_t chunk_b,        // Second owned row
    input  data_t  weight_lo,      // Weight of the even column
    input  data_t  weight_hi,      // Weight of the odd column
    input  logic   slice_valid,
    input  logic   slice_last,
    output acc_t   result_a,
    output acc_t   result_b,
    output logic   core_done
);

    acc_t acc_a, acc_b;            // Running sums
    acc_t beat_a, beat_b;          // This beat's contribution

    // Two Q8.8 products at full width, rescaled by an arithmetic shift
    function automatic acc_t pair_sum(input chunk_t chunk, input data_t w_lo, input data_t w_hi);
        acc_t p_lo;
        acc_t p_hi;
        p_lo = data_t'(chunk[0 +: `MM_WIDTH]) * w_lo;
        p_hi = data_t'(chunk[`MM_WIDTH +: `MM_WIDTH]) * w_hi;
        return (p_lo >>> `MM_FRAC_WIDTH) + (p_hi >>> `MM_FRAC_WIDTH); // Wraps
    endfunction

    assign beat_a = pair_sum(chunk_a, weight_lo, weight_hi);
    assign beat_b = pair_sum(chunk_b, weight_lo, weight_hi);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_a     <= '0;
            acc_b     <= '0;
            core_done <= 1'b0;
        end else begin
            core_done <= slice_valid && slice_last;   // Single cycle pulse
            if (slice_valid) begin
                if (slice_last) begin
                    acc_a <= '0;                      // Fresh start next block
                    acc_b <= '0;
                end else begin
                    acc_a <= acc_a + beat_a;
                    acc_b <= acc_b + beat_b;
                end
            end
        end
    end

    // Final sums include the last beat
    always_ff @(posedge clk) begin
        if (slice_valid && slice_last) begin
            result_a <= acc_a + beat_a;
            result_b <= acc_b + beat_b;
        end
    end

endmodule

// File: source/mm_macros.svh
/* Matrix-vector engine dimensions, number format and APB register map */
`ifndef MM_MACROS_SVH
`define MM_MACROS_SVH

// Matrix shape
`define MM_COL         8                               // Elements per row
`define MM_BLOCK_SIZE  2                               // Rows per core, columns per beat
`define MM_NUM_CORES   2
`define MM_BLOCK_ROWS  (`MM_BLOCK_SIZE * `MM_NUM_CORES) // 4 rows buffered
`define MM_BEATS       (`MM_COL / `MM_BLOCK_SIZE)       // 4 slice beats

// Fixed point, Q8.8 data
`define MM_WIDTH       16
`define MM_FRAC_WIDTH  8
`define MM_ACC_WIDTH   32

// APB map
`define MM_ADDR_WIDTH  8
`define MM_ADDR_WEIGHT 8'h00                           // W0..W7
`define MM_ADDR_RESULT 8'h20                           // R0..R3, read only
`define MM_ADDR_STATUS 8'h30                           // Pending flag and block count

`endif

// File: source/mm_pkg.sv
/* Shared types of the matrix-vector engine: data words, packed rows and slices,
   beat and address indices, reorder buffer states */
`include "mm_macros.svh"

package mm_pkg;

    // Q8.8 element and wide accumulator, both signed
    typedef logic signed [`MM_WIDTH-1:0]     data_t;
    typedef logic signed [`MM_ACC_WIDTH-1:0] acc_t;

    // Full row, element 0 in the low bits
    typedef logic [`MM_COL*`MM_WIDTH-1:0] row_t;

    // BLOCK_SIZE neighbouring elements of one row
    typedef logic [`MM_BLOCK_SIZE*`MM_WIDTH-1:0] chunk_t;

    // One chunk per buffered row, row 0 lowest
    typedef logic [`MM_BLOCK_ROWS*`MM_BLOCK_SIZE*`MM_WIDTH-1:0] slice_t;

    typedef logic [$clog2(`MM_BEATS)-1:0] beat_t;     // Column pair index
    typedef logic [`MM_ADDR_WIDTH-1:0]    addr_t;

    // FILL takes rows, WAIT stalls on unread results, SLICE replays columns
    typedef enum logic [1:0] {
        FILL  = 2'd0,
        WAIT  = 2'd1,
        SLICE = 2'd2
    } n2r_state_t;

endpackage

// File: source/mm_top.sv
/* Matrix-vector engine top: row stream into the reorder buffer, two MAC cores on
   the column slices, APB registers for weights and results */
`timescale 1ns/1ns
`include "mm_macros.svh"

module mm_top import mm_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // Row stream
    input  row_t        row_data,
    input  logic        row_valid,
    output logic        row_ready,
    // APB3 slave
    input  addr_t       paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    localparam int CHUNK_W = $bits(chunk_t);

    slice_t slice_data;
    logic   slice_valid, slice_last;
    beat_t  slice_beat;
    logic   results_pending;
    logic   block_done;                     // Core 0 done, cores run in lockstep
    acc_t   result_0, result_1, result_2, result_3;
    data_t  weights [0:`MM_COL-1];
    data_t  weight_lo, weight_hi;

    // Weight pair of the current column pair
    assign weight_lo = weights[`MM_BLOCK_SIZE*slice_beat];
    assign weight_hi = weights[`MM_BLOCK_SIZE*slice_beat + 1];

    n2r_buffer u_n2r (
        .clk, .rst_n,
        .row_data, .row_valid, .row_ready,
        .results_pending,
        .slice_data, .slice_valid, .slice_last, .slice_beat
    );

    // Core 0 owns rows 0 and 1
    mac_core u_core0 (
        .clk, .rst_n,
        .chunk_a     (slice_data[0*CHUNK_W +: CHUNK_W]),
        .chunk_b     (slice_data[1*CHUNK_W +: CHUNK_W]),
        .weight_lo, .weight_hi, .slice_valid, .slice_last,
        .result_a    (result_0),
        .result_b    (result_1),
        .core_done   (block_done)
    );

    // Core 1 owns rows 2 and 3
    mac_core u_core1 (
        .clk, .rst_n,
        .chunk_a     (slice_data[2*CHUNK_W +: CHUNK_W]),
        .chunk_b     (slice_data[3*CHUNK_W +: CHUNK_W]),
        .weight_lo, .weight_hi, .slice_valid, .slice_last,
        .result_a    (result_2),
        .result_b    (result_3),
        .core_done   ()
    );

    apb_regs u_regs (
        .clk, .rst_n,
        .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .result_0, .result_1, .result_2, .result_3,
        .block_done,
        .weight_0 (weights[0]), .weight_1 (weights[1]),
        .weight_2 (weights[2]), .weight_3 (weights[3]),
        .weight_4 (weights[4]), .weight_5 (weights[5]),
        .weight_6 (weights[6]), .weight_7 (weights[7]),
        .results_pending
    );

endmodule

// File: source/n2r_buffer.sv
/* Normal-to-ready reorder buffer: gathers one block of rows from the stream and
   replays it as column slices, BLOCK_SIZE columns of every row per beat */
`timescale 1ns/1ns
`include "mm_macros.svh"

module n2r_buffer import mm_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    // Row stream in
    input  row_t   row_data,
    input  logic   row_valid,
    output logic   row_ready,
    // Back-pressure from the register block
    input  logic   results_pending,
    // Slice stream out, no stall
    output slice_t slice_data,
    output logic   slice_valid,
    output logic   slice_last,
    output beat_t  slice_beat
);

    localparam int CHUNK_W = $bits(chunk_t);
    localparam int CNT_W   = $clog2(`MM_BLOCK_ROWS);

    n2r_state_t       state;
    row_t             rows [0:`MM_BLOCK_ROWS-1];    // Row store
    logic [CNT_W-1:0] row_cnt;                      // Next free entry
    beat_t            beat;
    logic             row_fire;
    logic             block_full;

    assign row_ready  = (state == FILL);
    assign row_fire   = row_valid && row_ready;
    assign block_full = (row_cnt == CNT_W'(`MM_BLOCK_ROWS-1)); // Last entry being written

    assign slice_valid = (state == SLICE);
    assign slice_beat  = beat;
    assign slice_last  = slice_valid && (beat == beat_t'(`MM_BEATS-1));

    // Pick column pair 'beat' from every stored row
    always_comb begin
        for (int r = 0; r < `MM_BLOCK_ROWS; r++) begin
            slice_data[r*CHUNK_W +: CHUNK_W] = rows[r][beat*CHUNK_W +: CHUNK_W];
        end
    end

    // Row storage, payload only
    always_ff @(posedge clk) begin
        if (row_fire) begin
            rows[row_cnt] <= row_data;
        end
    end

    // Control FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= FILL;
            row_cnt <= '0;
            beat    <= '0;
        end else begin
            case (state)
                FILL: begin
                    if (row_fire) begin
                        row_cnt <= row_cnt + 1'b1;          // Wraps back to entry 0
                        if (block_full) begin
                            // Old results still unread, hold the block
                            state <= results_pending ? WAIT : SLICE;
                        end
                    end
                end
                WAIT: begin
                    if (!results_pending) begin
                        state <= SLICE;
                    end
                end
                SLICE: begin
                    beat <= beat + 1'b1;
                    if (slice_last) begin
                        beat  <= '0;
                        state <= FILL;                      // Store free again
                    end
                end
                default: state <= FILL;
            endcase
        end
    end

endmodule

// File: verification/tb_mm_top.sv
/* Self-checking testbench for the matrix-vector engine with random rows and weights
   over the row stream and APB, results checked against a reference model */
`timescale 1ns/1ns
`include "mm_macros.svh"

module tb_mm_top import mm_pkg::*; ();

    localparam int HALF        = 50;          // 100 ns clock
    localparam int ROW_TIMEOUT = 20;          // Cycles to wait for row_ready
    localparam int POLL_LIMIT  = 30;          // Status reads before giving up

    logic        clk;
    logic        rst_n;
    row_t        row_data;
    logic        row_valid;
    logic        row_ready;
    addr_t       paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer      seed;
    int          err_count;
    int          timeout_count;
    data_t       model_w    [0:`MM_COL-1];         // Weights as the model sees them
    row_t        model_rows [0:`MM_BLOCK_ROWS-1];  // Current block
    acc_t        expected   [0:`MM_BLOCK_ROWS-1];
    logic [7:0]  model_count;                      // Wraps like the status field
    logic        model_pending;

    mm_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .row_data  (row_data),
        .row_valid (row_valid),
        .row_ready (row_ready),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    initial clk = 1'b0;
    always #HALF clk = ~clk;

    task automatic check_result(input string name, input acc_t exp, input acc_t act);
        if (act !== exp) begin
            err_count++;
            $display("Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            err_count++;
            $display("Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_count++;
            $display("Error %s: expected 0x%h, actual 0x%h", name, exp, act);
        end
    endtask

    // Setup cycle then access cycle sampled halfway through
    task automatic apb_write(input addr_t addr, input logic [31:0] data, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #(HALF/2);
        check_flag("pready", 1'b1, pready);   // No wait states
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input addr_t addr, output logic [31:0] data, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #(HALF/2);
        check_flag("pready", 1'b1, pready);
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Q8.8 dot product with full width products shifted right by 8 and a wrapping sum
    function automatic acc_t model_dot(input row_t row);
        acc_t  sum;
        acc_t  prod;
        data_t a;
        sum = '0;
        for (int c = 0; c < `MM_COL; c++) begin
            a    = row[c*`MM_WIDTH +: `MM_WIDTH];
            prod = acc_t'(a) * acc_t'(model_w[c]);
            sum  = sum + (prod >>> `MM_FRAC_WIDTH);
        end
        return sum;
    endfunction

    task automatic fill_rows();
        logic [31:0] tmp;
        for (int r = 0; r < `MM_BLOCK_ROWS; r++) begin
            for (int c = 0; c < `MM_COL; c++) begin
                tmp = $random(seed);
                model_rows[r][c*`MM_WIDTH +: `MM_WIDTH] = tmp[15:0];  // Full signed range
            end
        end
    endtask

    task automatic compute_expected();
        for (int r = 0; r < `MM_BLOCK_ROWS; r++) begin
            expected[r] = model_dot(model_rows[r]);
        end
    endtask

    task automatic set_random_weights();
        logic [31:0] tmp;
        logic        err;
        for (int c = 0; c < `MM_COL; c++) begin
            tmp = $random(seed);
            apb_write(addr_t'(`MM_ADDR_WEIGHT + 4*c), tmp, err);
            check_flag("pslverr", 1'b0, err);
            model_w[c] = tmp[15:0];           // Upper half ignored
        end
    endtask

    // Holds valid until accepted or timed out
    task automatic send_row(input row_t data, output logic accepted);
        int waited;
        waited = 0;
        accepted = 1'b0;
        @(negedge clk);
        row_data  = data;
        row_valid = 1'b1;
        while (!accepted && waited < ROW_TIMEOUT) begin
            #(HALF/2);
            if (row_ready === 1'b1) begin
                accepted = 1'b1;              // Transfer on the coming edge
            end
            @(negedge clk);
            waited++;
        end
        row_valid = 1'b0;
    endtask

    task automatic send_block();
        logic ok;
        for (int r = 0; r < `MM_BLOCK_ROWS; r++) begin
            send_row(model_rows[r], ok);
            if (!ok) begin
                timeout_count++;
                $display("Timeout: row %0d of the block was never accepted", r);
            end
        end
    endtask

    // Poll status until the block is done and then advance the model
    task automatic wait_pending();
        logic [31:0] rd;
        logic        err;
        int          polls;
        polls = 0;
        rd = '0;
        while (rd[0] !== 1'b1 && polls < POLL_LIMIT) begin
            apb_read(`MM_ADDR_STATUS, rd, err);
            check_flag("pslverr", 1'b0, err);
            polls++;
        end
        if (rd[0] !== 1'b1) begin
            timeout_count++;
            $display("Timeout: results never became pending");
        end
        model_pending = 1'b1;
        model_count   = model_count + 1'b1;
    endtask

    task automatic check_block();
        logic [31:0] rd;
        logic        err;
        for (int r = 0; r < `MM_BLOCK_ROWS; r++) begin
            apb_read(addr_t'(`MM_ADDR_RESULT + 4*r), rd, err);
            check_flag("pslverr", 1'b0, err);
            check_result($sformatf("R%0d", r), expected[r], acc_t'(rd));
        end
        apb_read(`MM_ADDR_STATUS, rd, err);
        check_flag("pslverr", 1'b0, err);
        check_word("status", {16'h0, model_count, 7'h0, model_pending}, rd);
    endtask

    task automatic clear_pending();
        logic err;
        apb_write(`MM_ADDR_STATUS, 32'h1, err);   // Write 1 to clear
        check_flag("pslverr", 1'b0, err);
        model_pending = 1'b0;
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        logic        ok;
        row_t        extra;
        seed          = 32'h6af2;
        err_count     = 0;
        timeout_count = 0;
        model_count   = '0;
        model_pending = 1'b0;
        for (int c = 0; c < `MM_COL; c++) begin
            model_w[c] = '0;
        end
        rst_n     = 1'b0;
        row_data  = '0;
        row_valid = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Reset values
        apb_read(`MM_ADDR_STATUS, rd, err);
        check_word("status", 32'h0, rd);
        for (int c = 0; c < `MM_COL; c++) begin
            apb_read(addr_t'(`MM_ADDR_WEIGHT + 4*c), rd, err);
            check_word($sformatf("W%0d", c), 32'h0, rd);
        end
        #(HALF/2);
        check_flag("row_ready", 1'b1, row_ready);

        // Weight readback and error responses
        set_random_weights();
        for (int c = 0; c < `MM_COL; c++) begin
            apb_read(addr_t'(`MM_ADDR_WEIGHT + 4*c), rd, err);
            check_word($sformatf("W%0d", c), {16'h0, model_w[c]}, rd);
        end
        apb_write(`MM_ADDR_RESULT, 32'h1234, err);
        check_flag("pslverr", 1'b1, err);    // Results are read only
        apb_read(8'h40, rd, err);
        check_flag("pslverr", 1'b1, err);    // Unmapped

        // Single block
        set_random_weights();
        fill_rows();
        compute_expected();
        send_block();
        wait_pending();
        check_block();

        // Back-pressure with status left uncleared
        fill_rows();
        send_block();                         // Fills the store and moves to WAIT
        extra = {$random(seed), $random(seed), $random(seed), $random(seed)};
        send_row(extra, ok);
        if (ok) begin
            err_count++;
            $display("Ninth row was accepted while results were still pending");
        end
        #(HALF/2);
        check_flag("row_ready", 1'b0, row_ready);
        check_block();                        // First block's results untouched
        compute_expected();
        clear_pending();
        wait_pending();
        check_block();

        // Soak with new weights every block
        clear_pending();
        for (int b = 0; b < 20; b++) begin
            set_random_weights();
            fill_rows();
            compute_expected();
            send_block();
            wait_pending();
            check_block();
            clear_pending();
        end

        $display("Value errors: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
